//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_warp_sched -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_warp_sched)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sources.f
verilog/sched_pkg.sv
verilog/warp_table.sv
verilog/barrier_unit.sv
verilog/warp_select.sv
verilog/pending_tracker.sv
verilog/warp_sched.sv
tb/tb_warp_sched.sv

//--- tb/tb_warp_sched.sv
// table-driven testbench for the warp scheduler, run as top module with the file list
`timescale 1ns/1ps

module tb_warp_sched;
    import sched_pkg::*;

    localparam int NSTEPS         = 23;
    localparam int TIMEOUT_CYCLES = 40 * NSTEPS;
    localparam int WAIT_LIMIT     = 20;
    localparam int IDLE_CYCLES    = 4;

    // strobe kinds
    localparam int S_NONE   = 0;
    localparam int S_TMC    = 1;
    localparam int S_SPAWN  = 2;
    localparam int S_BAR    = 3;
    localparam int S_BR_T   = 4;
    localparam int S_BR_N   = 5;
    localparam int S_UNLOCK = 6;
    localparam int S_ISSUE  = 7;
    localparam int S_COMMIT = 8;

    // check kinds
    localparam int C_SCHED = 0;
    localparam int C_BUSY  = 1;
    localparam int C_IDLE  = 2;

    logic                   clk;
    logic                   reset;
    logic                   warp_ctl_valid;
    logic [NW_WIDTH-1:0]    warp_ctl_wid;
    logic [OP_WIDTH-1:0]    warp_ctl_op;
    logic [PC_BITS-1:0]     warp_ctl_pc;
    warp_ctl_payload_t      warp_ctl_payload;
    logic                   branch_valid;
    logic [NW_WIDTH-1:0]    branch_wid;
    logic                   branch_taken;
    logic [PC_BITS-1:0]     branch_dest;
    logic                   decode_unlock;
    logic [NW_WIDTH-1:0]    decode_wid;
    logic                   issue_valid;
    logic [NW_WIDTH-1:0]    issue_wid;
    logic                   commit_valid;
    logic [NW_WIDTH-1:0]    commit_wid;
    logic                   sched_ready;
    logic                   sched_valid;
    logic [NW_WIDTH-1:0]    sched_wid;
    logic [NUM_THREADS-1:0] sched_tmask;
    logic [PC_BITS-1:0]     sched_pc;
    logic                   busy;

    // step table
    string                  step_name [NSTEPS];
    bit                     step_rand [NSTEPS];
    int                     step_kind [NSTEPS];
    logic [NW_WIDTH-1:0]    step_wid  [NSTEPS];
    logic [PC_BITS-1:0]     step_addr [NSTEPS];
    logic [NUM_THREADS-1:0] step_load [NSTEPS];
    int                     step_chk  [NSTEPS];
    logic [NW_WIDTH-1:0]    exp_wid   [NSTEPS];
    logic [NUM_THREADS-1:0] exp_tmask [NSTEPS];
    // expected pc, or busy in bit 0
    logic [PC_BITS-1:0]     exp_value [NSTEPS];

    int          n_steps     = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state;
    bit          step_ok;

    warp_sched #(
        .START_PC (32'h100)
    ) i_warp_sched (
        .clk              (clk),
        .reset            (reset),
        .warp_ctl_valid   (warp_ctl_valid),
        .warp_ctl_wid     (warp_ctl_wid),
        .warp_ctl_op      (warp_ctl_op),
        .warp_ctl_pc      (warp_ctl_pc),
        .warp_ctl_payload (warp_ctl_payload),
        .branch_valid     (branch_valid),
        .branch_wid       (branch_wid),
        .branch_taken     (branch_taken),
        .branch_dest      (branch_dest),
        .decode_unlock    (decode_unlock),
        .decode_wid       (decode_wid),
        .issue_valid      (issue_valid),
        .issue_wid        (issue_wid),
        .commit_valid     (commit_valid),
        .commit_wid       (commit_wid),
        .sched_ready      (sched_ready),
        .sched_valid      (sched_valid),
        .sched_wid        (sched_wid),
        .sched_tmask      (sched_tmask),
        .sched_pc         (sched_pc),
        .busy             (busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without reaching the end", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_step(input string name, input int rnd, input int kind, input int wid,
                            input logic [PC_BITS-1:0] addr, input logic [NUM_THREADS-1:0] load,
                            input int chk, input int ewid, input logic [NUM_THREADS-1:0] etmask,
                            input logic [PC_BITS-1:0] evalue);
        step_name[n_steps] = name;
        step_rand[n_steps] = (rnd != 0);
        step_kind[n_steps] = kind;
        step_wid[n_steps]  = NW_WIDTH'(wid);
        step_addr[n_steps] = addr;
        step_load[n_steps] = load;
        step_chk[n_steps]  = chk;
        exp_wid[n_steps]   = NW_WIDTH'(ewid);
        exp_tmask[n_steps] = etmask;
        exp_value[n_steps] = evalue;
        n_steps++;
    endtask

    task automatic load_table();
        add_step("reset_offer", 0, S_NONE, 0, 32'h0, 4'b0000, C_SCHED, 0, 4'b0001, 32'h100);
        add_step("unlock_w0", 0, S_UNLOCK, 0, 32'h0, 4'b0000, C_SCHED, 0, 4'b0001, 32'h104);
        add_step("branch_taken", 0, S_BR_T, 0, 32'h200, 4'b0000, C_SCHED, 0, 4'b0001, 32'h200);
        add_step("branch_not_taken", 0, S_BR_N, 0, 32'h280, 4'b0000, C_SCHED, 0, 4'b0001,
                 32'h204);
        // spawn from warp 0 while it runs alone, under random back-pressure
        add_step("spawn_issuer", 1, S_SPAWN, 0, 32'h300, 4'b1110, C_SCHED, 0, 4'b0001, 32'h208);
        add_step("spawn_w1", 1, S_NONE, 0, 32'h0, 4'b0000, C_SCHED, 1, 4'b0001, 32'h300);
        add_step("spawn_w2", 1, S_NONE, 0, 32'h0, 4'b0000, C_SCHED, 2, 4'b0001, 32'h300);
        add_step("spawn_w3", 1, S_NONE, 0, 32'h0, 4'b0000, C_SCHED, 3, 4'b0001, 32'h300);
        add_step("respawn_ignored", 1, S_SPAWN, 1, 32'h400, 4'b1000, C_SCHED, 1, 4'b0001,
                 32'h304);
        // warp 3 would restart at 0x400 had the second spawn taken effect
        add_step("w3_keeps_pc", 1, S_UNLOCK, 3, 32'h0, 4'b0000, C_SCHED, 3, 4'b0001, 32'h304);
        add_step("tmc_w2", 0, S_TMC, 2, 32'h0, 4'b1010, C_SCHED, 2, 4'b1010, 32'h304);
        add_step("tmc_w3_empty", 0, S_TMC, 3, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("w3_stays_off", 0, S_UNLOCK, 3, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        // payload is barrier id 1 then size_m1 1
        add_step("bar_first", 0, S_BAR, 1, 32'h0, {2'd1, 2'd1}, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("bar_last", 0, S_BAR, 2, 32'h0, {2'd1, 2'd1}, C_SCHED, 1, 4'b0001, 32'h308);
        add_step("bar_w2", 0, S_NONE, 0, 32'h0, 4'b0000, C_SCHED, 2, 4'b1010, 32'h308);
        add_step("issue_1", 0, S_ISSUE, 1, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("issue_2", 0, S_ISSUE, 1, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("commit_1", 0, S_COMMIT, 1, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("retire_w0", 0, S_TMC, 0, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("retire_w1", 0, S_TMC, 1, 32'h0, 4'b0000, C_IDLE, 0, 4'b0000, 32'h0);
        add_step("retire_w2", 0, S_TMC, 2, 32'h0, 4'b0000, C_BUSY, 0, 4'b0000, 32'h1);
        add_step("commit_2", 0, S_COMMIT, 1, 32'h0, 4'b0000, C_BUSY, 0, 4'b0000, 32'h0);
    endtask

    task automatic clear_strobes();
        warp_ctl_valid   = 1'b0;
        warp_ctl_wid     = '0;
        warp_ctl_op      = '0;
        warp_ctl_pc      = '0;
        warp_ctl_payload = '0;
        branch_valid     = 1'b0;
        branch_wid       = '0;
        branch_taken     = 1'b0;
        branch_dest      = '0;
        decode_unlock    = 1'b0;
        decode_wid       = '0;
        issue_valid      = 1'b0;
        issue_wid        = '0;
        commit_valid     = 1'b0;
        commit_wid       = '0;
    endtask

    task automatic drive_strobe(input int k);
        int kind;
        kind             = step_kind[k];
        warp_ctl_wid     = step_wid[k];
        branch_wid       = step_wid[k];
        decode_wid       = step_wid[k];
        issue_wid        = step_wid[k];
        commit_wid       = step_wid[k];
        warp_ctl_pc      = step_addr[k];
        branch_dest      = step_addr[k];
        warp_ctl_payload = step_load[k];
        warp_ctl_valid   = (kind == S_TMC) || (kind == S_SPAWN) || (kind == S_BAR);
        case (kind)
            S_SPAWN: warp_ctl_op = OP_WSPAWN;
            S_BAR:   warp_ctl_op = OP_BARRIER;
            default: warp_ctl_op = OP_TMC;
        endcase
        branch_valid  = (kind == S_BR_T) || (kind == S_BR_N);
        branch_taken  = (kind == S_BR_T);
        decode_unlock = (kind == S_UNLOCK);
        issue_valid   = (kind == S_ISSUE);
        commit_valid  = (kind == S_COMMIT);
    endtask

    task automatic drive_ready(input int k);
        if (step_rand[k]) begin
            rng_state   = xorshift32(rng_state);
            sched_ready = (rng_state[1:0] != 2'b00);
        end else begin
            sched_ready = 1'b1;
        end
    endtask

    // wait for the transfer of one offer, checking it holds while ready is low
    task automatic check_offer(input int k);
        int                                      waited;
        bit                                      found;
        bit                                      held;
        logic [NW_WIDTH+NUM_THREADS+PC_BITS-1:0] held_word;
        waited    = 0;
        found     = 0;
        held      = 0;
        held_word = '0;
        while (!found && waited < WAIT_LIMIT) begin
            drive_ready(k);
            if (sched_valid) begin
                assert (!held || held_word == {sched_wid, sched_tmask, sched_pc}) else begin
                    $display("%s: offer changed while held by back-pressure", step_name[k]);
                    step_ok = 0;
                end
                held      = !sched_ready;
                held_word = {sched_wid, sched_tmask, sched_pc};
                if (sched_ready) begin
                    found = 1;
                    assert (sched_wid == exp_wid[k] && sched_tmask == exp_tmask[k]
                            && sched_pc == exp_value[k]) else begin
                        $write("FAIL %s: expected wid %0d tmask %b pc 0x%h",
                               step_name[k], exp_wid[k], exp_tmask[k], exp_value[k]);
                        $display(", actual wid %0d tmask %b pc 0x%h",
                                 sched_wid, sched_tmask, sched_pc);
                        step_ok = 0;
                    end
                end
            end else begin
                assert (!held) else begin
                    $display("%s: offer withdrawn while held by back-pressure", step_name[k]);
                    step_ok = 0;
                end
                held = 0;
            end
            @(negedge clk);
            clear_strobes();
            waited++;
        end
        assert (found) else begin
            $display("%s: no offer from the DUT within %0d cycles", step_name[k], WAIT_LIMIT);
            step_ok = 0;
        end
    endtask

    task automatic check_idle(input int k);
        repeat (IDLE_CYCLES) begin
            sched_ready = 1'b1;
            assert (!sched_valid) else begin
                $display("%s: unexpected offer of warp %0d", step_name[k], sched_wid);
                step_ok = 0;
            end
            @(negedge clk);
            clear_strobes();
        end
    endtask

    // busy is registered behind the counters, so it settles two edges after the strobe
    task automatic check_busy(input int k);
        sched_ready = 1'b1;
        @(negedge clk);
        clear_strobes();
        @(negedge clk);
        assert (busy == exp_value[k][0]) else begin
            $display("FAIL %s: expected busy %0b, actual busy %0b",
                     step_name[k], exp_value[k][0], busy);
            step_ok = 0;
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        sched_ready = 1'b1;
        rng_state   = 32'd96325;
        clear_strobes();
        load_table();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < n_steps; k++) begin
            step_ok = 1;
            drive_strobe(k);
            case (step_chk[k])
                C_SCHED: check_offer(k);
                C_BUSY:  check_busy(k);
                default: check_idle(k);
            endcase
            if (step_ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("step %0d %s: %s", k + 1, step_name[k], step_ok ? "passed" : "failed");
        end
        $display("steps passed %0d, steps failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/barrier_unit.sv
// local barrier counters and arrival masks, raising a release mask on the last arrival
`timescale 1ns/1ps

module barrier_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              warp_ctl_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    warp_ctl_wid,
    input  logic [sched_pkg::OP_WIDTH-1:0]    warp_ctl_op,
    input  sched_pkg::warp_ctl_payload_t      warp_ctl_payload,
    output logic                              release_valid,
    output logic [sched_pkg::NUM_WARPS-1:0]   release_mask
);
    import sched_pkg::*;

    logic [NUM_BARRIERS-1:0][NW_WIDTH-1:0]  bar_ctrs;
    logic [NUM_BARRIERS-1:0][NUM_WARPS-1:0] bar_masks;
    logic [NB_WIDTH-1:0]                    bar_id;
    logic [NUM_WARPS-1:0]                   arrive_mask;
    logic [NUM_WARPS-1:0]                   mask_p1;
    logic                                   is_barrier;
    logic                                   last_arrival;

    assign is_barrier = warp_ctl_valid && (warp_ctl_op == OP_BARRIER);
    assign bar_id     = warp_ctl_payload.bar.id;

    assign arrive_mask  = NUM_WARPS'(1) << warp_ctl_wid;
    // stored waiters plus the warp arriving now
    assign mask_p1      = bar_masks[bar_id] | arrive_mask;
    assign last_arrival = (bar_ctrs[bar_id] == warp_ctl_payload.bar.size_m1);

    assign release_valid = is_barrier && last_arrival;
    assign release_mask  = mask_p1;

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_ctrs  <= '0;
            bar_masks <= '0;
        end else if (is_barrier) begin
            if (last_arrival) begin
                bar_ctrs[bar_id]  <= '0;
                bar_masks[bar_id] <= '0;
            end else begin
                bar_ctrs[bar_id]  <= bar_ctrs[bar_id] + NW_WIDTH'(1);
                bar_masks[bar_id] <= mask_p1;
            end
        end
    end

endmodule

//--- verilog/pending_tracker.sv
// per-warp in-flight instruction counts from issue and commit, giving a registered busy
`timescale 1ns/1ps

module pending_tracker #(
    parameter int PENDING_DEPTH = 64
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              issue_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    issue_wid,
    input  logic                              commit_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    commit_wid,
    input  logic [sched_pkg::NUM_WARPS-1:0]   active_warps,
    output logic                              busy
);
    import sched_pkg::*;

    localparam int CNT_BITS = $clog2(PENDING_DEPTH + 1);

    logic [NUM_WARPS-1:0][CNT_BITS-1:0] pending_cnt;
    logic [NUM_WARPS-1:0]               pending_nz;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_cnt <= '0;
        end else begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                // issue and commit together cancel out
                if (issue_valid && (issue_wid == NW_WIDTH'(i))
                    && !(commit_valid && (commit_wid == NW_WIDTH'(i)))) begin
                    pending_cnt[i] <= pending_cnt[i] + CNT_BITS'(1);
                end else if (commit_valid && (commit_wid == NW_WIDTH'(i))
                    && !(issue_valid && (issue_wid == NW_WIDTH'(i)))) begin
                    pending_cnt[i] <= pending_cnt[i] - CNT_BITS'(1);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            pending_nz[i] = (pending_cnt[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (|active_warps) || (|pending_nz);
        end
    end

endmodule

//--- verilog/sched_pkg.sv
// shared widths, warp-control op codes and payload type for the warp scheduler RTL
package sched_pkg;

    // core geometry
    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NUM_BARRIERS = 4;
    localparam int PC_BITS      = 32;

    // index widths
    localparam int NW_WIDTH = 2;
    localparam int NB_WIDTH = 2;

    // warp-control op codes where zero means no operation
    localparam int OP_WIDTH = 2;
    localparam logic [OP_WIDTH-1:0] OP_NONE    = 2'd0;
    localparam logic [OP_WIDTH-1:0] OP_TMC     = 2'd1;
    localparam logic [OP_WIDTH-1:0] OP_WSPAWN  = 2'd2;
    localparam logic [OP_WIDTH-1:0] OP_BARRIER = 2'd3;

    // barrier request view of the payload
    typedef struct packed {
        logic [NB_WIDTH-1:0] id;
        // number of arriving warps minus one
        logic [NW_WIDTH-1:0] size_m1;
    } barrier_req_t;

    // one payload word, read by op code
    // tmc reads a thread mask, wspawn reads a warp mask (same width here)
    typedef union packed {
        logic [NUM_THREADS-1:0] mask;
        barrier_req_t           bar;
    } warp_ctl_payload_t;

endpackage

//--- verilog/warp_sched.sv
// warp scheduler top level, wiring state table, barriers, selection and pending tracking
`timescale 1ns/1ps

module warp_sched #(
    parameter logic [sched_pkg::PC_BITS-1:0] START_PC = '0,
    parameter int PENDING_DEPTH = 64
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              warp_ctl_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    warp_ctl_wid,
    input  logic [sched_pkg::OP_WIDTH-1:0]    warp_ctl_op,
    input  logic [sched_pkg::PC_BITS-1:0]     warp_ctl_pc,
    input  sched_pkg::warp_ctl_payload_t      warp_ctl_payload,
    input  logic                              branch_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    branch_wid,
    input  logic                              branch_taken,
    input  logic [sched_pkg::PC_BITS-1:0]     branch_dest,
    input  logic                              decode_unlock,
    input  logic [sched_pkg::NW_WIDTH-1:0]    decode_wid,
    input  logic                              issue_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    issue_wid,
    input  logic                              commit_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]    commit_wid,
    input  logic                              sched_ready,
    output logic                              sched_valid,
    output logic [sched_pkg::NW_WIDTH-1:0]    sched_wid,
    output logic [sched_pkg::NUM_THREADS-1:0] sched_tmask,
    output logic [sched_pkg::PC_BITS-1:0]     sched_pc,
    output logic                              busy
);
    import sched_pkg::*;

    logic                                  release_valid;
    logic [NUM_WARPS-1:0]                  release_mask;
    logic [NUM_WARPS-1:0]                  ready_warps;
    logic [NUM_WARPS-1:0]                  active_warps;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] thread_masks;
    logic [NUM_WARPS-1:0][PC_BITS-1:0]     warp_pcs;
    logic                                  sel_fire;
    logic [NW_WIDTH-1:0]                   sel_wid;

    warp_table #(
        .START_PC (START_PC)
    ) i_warp_table (
        .clk              (clk),
        .reset            (reset),
        .warp_ctl_valid   (warp_ctl_valid),
        .warp_ctl_wid     (warp_ctl_wid),
        .warp_ctl_op      (warp_ctl_op),
        .warp_ctl_pc      (warp_ctl_pc),
        .warp_ctl_payload (warp_ctl_payload),
        .branch_valid     (branch_valid),
        .branch_wid       (branch_wid),
        .branch_taken     (branch_taken),
        .branch_dest      (branch_dest),
        .decode_unlock    (decode_unlock),
        .decode_wid       (decode_wid),
        .release_valid    (release_valid),
        .release_mask     (release_mask),
        .sel_fire         (sel_fire),
        .sel_wid          (sel_wid),
        .ready_warps      (ready_warps),
        .active_warps     (active_warps),
        .thread_masks     (thread_masks),
        .warp_pcs         (warp_pcs)
    );

    barrier_unit i_barrier_unit (
        .clk              (clk),
        .reset            (reset),
        .warp_ctl_valid   (warp_ctl_valid),
        .warp_ctl_wid     (warp_ctl_wid),
        .warp_ctl_op      (warp_ctl_op),
        .warp_ctl_payload (warp_ctl_payload),
        .release_valid    (release_valid),
        .release_mask     (release_mask)
    );

    warp_select i_warp_select (
        .clk          (clk),
        .reset        (reset),
        .ready_warps  (ready_warps),
        .thread_masks (thread_masks),
        .warp_pcs     (warp_pcs),
        .sched_ready  (sched_ready),
        .sel_fire     (sel_fire),
        .sel_wid      (sel_wid),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_tmask  (sched_tmask),
        .sched_pc     (sched_pc)
    );

    pending_tracker #(
        .PENDING_DEPTH (PENDING_DEPTH)
    ) i_pending_tracker (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_wid    (issue_wid),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .active_warps (active_warps),
        .busy         (busy)
    );

endmodule

//--- verilog/warp_select.sv
// lowest-index ready warp pick feeding a one-entry valid/ready output register
`timescale 1ns/1ps

module warp_select (
    input  logic                                                        clk,
    input  logic                                                        reset,
    input  logic [sched_pkg::NUM_WARPS-1:0]                             ready_warps,
    input  logic [sched_pkg::NUM_WARPS-1:0][sched_pkg::NUM_THREADS-1:0] thread_masks,
    input  logic [sched_pkg::NUM_WARPS-1:0][sched_pkg::PC_BITS-1:0]     warp_pcs,
    input  logic                                                        sched_ready,
    output logic                                                        sel_fire,
    output logic [sched_pkg::NW_WIDTH-1:0]                              sel_wid,
    output logic                                                        sched_valid,
    output logic [sched_pkg::NW_WIDTH-1:0]                              sched_wid,
    output logic [sched_pkg::NUM_THREADS-1:0]                           sched_tmask,
    output logic [sched_pkg::PC_BITS-1:0]                               sched_pc
);
    import sched_pkg::*;

    logic [NW_WIDTH-1:0]    pick_wid;
    logic                   out_valid;
    logic [NW_WIDTH-1:0]    out_wid;
    logic [NUM_THREADS-1:0] out_tmask;
    logic [PC_BITS-1:0]     out_pc;

    // scan downward so the lowest set bit wins
    always_comb begin
        pick_wid = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                pick_wid = NW_WIDTH'(i);
            end
        end
    end

    // load when empty or draining this cycle
    assign sel_fire = (|ready_warps) && (!out_valid || sched_ready);
    assign sel_wid  = pick_wid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (sel_fire) begin
            out_valid <= 1'b1;
        end else if (sched_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_fire) begin
            out_wid   <= pick_wid;
            out_tmask <= thread_masks[pick_wid];
            out_pc    <= warp_pcs[pick_wid];
        end
    end

    assign sched_valid = out_valid;
    assign sched_wid   = out_wid;
    assign sched_tmask = out_tmask;
    assign sched_pc    = out_pc;

endmodule

//--- verilog/warp_table.sv
// per-warp active, stall, thread mask and PC state, updated by control strobes and issue
`timescale 1ns/1ps

module warp_table #(
    parameter logic [sched_pkg::PC_BITS-1:0] START_PC = '0
) (
    input  logic                                                clk,
    input  logic                                                reset,
    // warp control
    input  logic                                                warp_ctl_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]                      warp_ctl_wid,
    input  logic [sched_pkg::OP_WIDTH-1:0]                      warp_ctl_op,
    input  logic [sched_pkg::PC_BITS-1:0]                       warp_ctl_pc,
    input  sched_pkg::warp_ctl_payload_t                        warp_ctl_payload,
    // branch resolution
    input  logic                                                branch_valid,
    input  logic [sched_pkg::NW_WIDTH-1:0]                      branch_wid,
    input  logic                                                branch_taken,
    input  logic [sched_pkg::PC_BITS-1:0]                       branch_dest,
    // decode unlock
    input  logic                                                decode_unlock,
    input  logic [sched_pkg::NW_WIDTH-1:0]                      decode_wid,
    // barrier release
    input  logic                                                release_valid,
    input  logic [sched_pkg::NUM_WARPS-1:0]                     release_mask,
    // selection
    input  logic                                                sel_fire,
    input  logic [sched_pkg::NW_WIDTH-1:0]                      sel_wid,
    output logic [sched_pkg::NUM_WARPS-1:0]                     ready_warps,
    output logic [sched_pkg::NUM_WARPS-1:0]                     active_warps,
    output logic [sched_pkg::NUM_WARPS-1:0][sched_pkg::NUM_THREADS-1:0] thread_masks,
    output logic [sched_pkg::NUM_WARPS-1:0][sched_pkg::PC_BITS-1:0]     warp_pcs
);
    import sched_pkg::*;

    logic [NUM_WARPS-1:0]                  active_r;
    logic [NUM_WARPS-1:0]                  active_n;
    logic [NUM_WARPS-1:0]                  stalled_r;
    logic [NUM_WARPS-1:0]                  stalled_n;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmask_r;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmask_n;
    logic [NUM_WARPS-1:0][PC_BITS-1:0]     pc_r;
    logic [NUM_WARPS-1:0][PC_BITS-1:0]     pc_n;
    logic                                  is_tmc;
    logic                                  is_wspawn;

    assign is_tmc    = warp_ctl_valid && (warp_ctl_op == OP_TMC);
    assign is_wspawn = warp_ctl_valid && (warp_ctl_op == OP_WSPAWN);

    always_comb begin
        active_n  = active_r;
        stalled_n = stalled_r;
        tmask_n   = tmask_r;
        pc_n      = pc_r;

        if (decode_unlock) begin
            stalled_n[decode_wid] = 1'b0;
        end

        // last barrier arrival frees every waiting warp
        if (release_valid) begin
            stalled_n = stalled_n & ~release_mask;
        end

        // spawn only from a single running warp
        if (is_wspawn) begin
            if ($onehot(active_r)) begin
                active_n = active_n | warp_ctl_payload.mask;
                for (int i = 0; i < NUM_WARPS; i++) begin
                    if (warp_ctl_payload.mask[i]) begin
                        tmask_n[i] = NUM_THREADS'(1);
                        pc_n[i]    = warp_ctl_pc;
                    end
                end
            end
            stalled_n[warp_ctl_wid] = 1'b0;
        end

        // empty mask retires the warp
        if (is_tmc) begin
            active_n[warp_ctl_wid]  = (warp_ctl_payload.mask != '0);
            tmask_n[warp_ctl_wid]   = warp_ctl_payload.mask;
            stalled_n[warp_ctl_wid] = 1'b0;
        end

        if (branch_valid) begin
            if (branch_taken) begin
                pc_n[branch_wid] = branch_dest;
            end
            stalled_n[branch_wid] = 1'b0;
        end

        // hold the warp until its instruction is decoded
        if (sel_fire) begin
            stalled_n[sel_wid] = 1'b1;
            pc_n[sel_wid]      = pc_r[sel_wid] + PC_BITS'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_r   <= NUM_WARPS'(1);
            stalled_r  <= '0;
            tmask_r    <= '0;
            tmask_r[0] <= NUM_THREADS'(1);
            pc_r       <= '0;
            pc_r[0]    <= START_PC;
        end else begin
            active_r  <= active_n;
            stalled_r <= stalled_n;
            tmask_r   <= tmask_n;
            pc_r      <= pc_n;
        end
    end

    assign ready_warps  = active_r & ~stalled_r;
    assign active_warps = active_r;
    assign thread_masks = tmask_r;
    assign warp_pcs     = pc_r;

endmodule
